// File: src/lcd_macros.svh
`ifndef LCD_MACROS_SVH
`define LCD_MACROS_SVH

// Pixel FIFO depth in 32-bit words
`define LCD_FIFO_DEPTH 16

// Width of the FIFO fill level, wide enough to hold a full count
`define LCD_LEVEL_W $clog2(`LCD_FIFO_DEPTH + 1)

// Cycles a write or read strobe is held low on the panel bus
`define LCD_STROBE_CYCLES 2

`endif

// File: src/lcd_pkg.sv
package lcd_pkg;

  // Pixel format selected by the control register
  typedef enum logic {
    FMT_RGB888 = 1'b0,
    FMT_RGB565 = 1'b1
  } pix_fmt_e;

  // Host register map
  typedef enum logic [1:0] {
    REG_CONTROL    = 2'd0,
    REG_NUM_PIXELS = 2'd1,
    REG_STATUS     = 2'd2
  } reg_addr_e;

  typedef struct packed {
    logic [7:0] pad;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  // Upper pixel goes out on the bus first
  typedef struct packed {
    logic [15:0] upper;
    logic [15:0] lower;
  } rgb565_pair_t;

  // One FIFO word read either as a single RGB888 pixel or as two RGB565 pixels
  typedef union packed {
    rgb888_t      rgb888;
    rgb565_pair_t rgb565;
  } pixel_word_u;

endpackage

// File: src/lcd_ctrl_regs.sv
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_ctrl_regs (
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  logic                      i_reg_wr,
  input  lcd_pkg::reg_addr_e        i_reg_addr,
  input  logic [31:0]               i_reg_wdata,
  input  logic [`LCD_LEVEL_W-1:0]   i_fifo_level,
  input  logic                      i_frame_busy,
  output logic [31:0]               o_reg_rdata,
  output logic                      o_enable,
  output logic                      o_reset_display,
  output logic                      o_data_mode,
  output logic                      o_tearing_en,
  output logic                      o_backlight,
  output logic                      o_chip_select,
  output lcd_pkg::pix_fmt_e         o_format,
  output logic [31:0]               o_num_pixels
);

  logic [6:0]  r_control;
  logic [31:0] r_num_pixels;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_control    <= '0;
      r_num_pixels <= '0;
    end else if (i_reg_wr) begin
      case (i_reg_addr)
        lcd_pkg::REG_CONTROL:    r_control    <= i_reg_wdata[6:0];
        lcd_pkg::REG_NUM_PIXELS: r_num_pixels <= i_reg_wdata;
        // Status is read only
        default: ;
      endcase
    end
  end

  // Control bit fields, from bit 0 upward
  assign o_enable        = r_control[0];
  assign o_reset_display = r_control[1];
  assign o_data_mode     = r_control[2];
  assign o_tearing_en    = r_control[3];
  assign o_backlight     = r_control[4];
  assign o_chip_select   = r_control[5];
  assign o_format        = lcd_pkg::pix_fmt_e'(r_control[6]);
  assign o_num_pixels    = r_num_pixels;

  // Status word carries the FIFO level in the low half and busy at bit 16
  always_comb begin
    o_reg_rdata = '0;
    case (i_reg_addr)
      lcd_pkg::REG_CONTROL:    o_reg_rdata = {25'd0, r_control};
      lcd_pkg::REG_NUM_PIXELS: o_reg_rdata = r_num_pixels;
      lcd_pkg::REG_STATUS: begin
        o_reg_rdata     = 32'(i_fifo_level);
        o_reg_rdata[16] = i_frame_busy;
      end
      default: o_reg_rdata = '0;
    endcase
  end

  a_status_write_ignored: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_reg_wr && i_reg_addr == lcd_pkg::REG_STATUS) |=>
      ($stable(r_control) && $stable(r_num_pixels)));

endmodule

// File: src/lcd_command.sv
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_command (
  input  logic       clk,
  input  logic       i_rst_n,
  input  logic       i_cmd_parameter,
  input  logic       i_cmd_write_stb,
  input  logic       i_cmd_read_stb,
  input  logic [7:0] i_cmd_data,
  input  logic [7:0] i_data_in,
  output logic [7:0] o_cmd_data,
  output logic       o_cmd_finished,
  output logic       o_cmd_mode,
  output logic       o_write,
  output logic       o_read,
  output logic [7:0] o_data_out,
  output logic       o_data_out_en
);

  localparam int CW = $clog2(`LCD_STROBE_CYCLES + 1);

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_SETUP = 3'd1;
  localparam logic [2:0] S_WRITE = 3'd2;
  localparam logic [2:0] S_HOLD  = 3'd3;
  localparam logic [2:0] S_READ  = 3'd4;
  localparam logic [2:0] S_DONE  = 3'd5;

  logic [2:0]    r_state;
  logic [CW-1:0] r_count;
  logic [7:0]    r_byte;
  logic [7:0]    r_rd_byte;
  logic          r_param;
  logic          w_start;
  logic          w_strobe_last;

  assign w_start       = (r_state == S_IDLE) && (i_cmd_write_stb || i_cmd_read_stb);
  assign w_strobe_last = (r_count == CW'(`LCD_STROBE_CYCLES - 1));

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state   <= S_IDLE;
      r_count   <= '0;
      r_param   <= 1'b0;
      r_rd_byte <= '0;
    end else begin
      case (r_state)
        S_IDLE: begin
          r_count <= '0;
          if (w_start) begin
            r_param <= i_cmd_parameter;
            // Writes get a setup cycle, reads strobe at once
            r_state <= i_cmd_write_stb ? S_SETUP : S_READ;
          end
        end
        S_SETUP: r_state <= S_WRITE;
        S_WRITE: begin
          r_count <= r_count + 1'b1;
          if (w_strobe_last) r_state <= S_HOLD;
        end
        S_READ: begin
          r_count <= r_count + 1'b1;
          if (w_strobe_last) begin
            // Sample on the last low cycle of the read strobe
            r_rd_byte <= i_data_in;
            r_state   <= S_DONE;
          end
        end
        default: r_state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (w_start) r_byte <= i_cmd_data;
  end

  assign o_cmd_mode     = r_param;
  assign o_data_out     = r_byte;
  assign o_cmd_data     = r_rd_byte;
  assign o_write        = (r_state == S_WRITE);
  assign o_read         = (r_state == S_READ);
  assign o_data_out_en  = (r_state == S_SETUP) || (r_state == S_WRITE) || (r_state == S_HOLD);
  assign o_cmd_finished = (r_state == S_HOLD) || (r_state == S_DONE);

  a_no_write_and_read: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(o_write && o_read));

  // A write takes setup, strobe and hold before it reports done
  a_write_finish_time: assert property (@(posedge clk) disable iff (!i_rst_n)
    (r_state == S_IDLE && i_cmd_write_stb) |-> ##(`LCD_STROBE_CYCLES + 2) o_cmd_finished);

endmodule

// File: src/lcd_pixel_fifo.sv
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_pixel_fifo (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  logic                    i_wr,
  input  logic [31:0]             i_wdata,
  input  logic                    i_rd,
  output logic [31:0]             o_rdata,
  output logic                    o_empty,
  output logic [`LCD_LEVEL_W-1:0] o_level
);

  localparam int DEPTH = `LCD_FIFO_DEPTH;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LW    = `LCD_LEVEL_W;

  logic [31:0]   r_mem [DEPTH];
  logic [AW-1:0] r_wr_ptr;
  logic [AW-1:0] r_rd_ptr;
  logic [LW-1:0] r_level;
  logic          w_full;
  logic          w_push;
  logic          w_pop;

  assign w_full  = (r_level == LW'(DEPTH));
  assign o_empty = (r_level == '0);
  assign w_push  = i_wr && !w_full;
  assign w_pop   = i_rd && !o_empty;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_level  <= '0;
    end else begin
      if (w_push) r_wr_ptr <= (r_wr_ptr == AW'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
      if (w_pop)  r_rd_ptr <= (r_rd_ptr == AW'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      case ({w_push, w_pop})
        2'b10:   r_level <= r_level + 1'b1;
        2'b01:   r_level <= r_level - 1'b1;
        default: r_level <= r_level;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (w_push) r_mem[r_wr_ptr] <= i_wdata;
  end

  // Head word is visible before the pop
  assign o_rdata = r_mem[r_rd_ptr];
  assign o_level = r_level;

  a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n) i_wr |-> !w_full);
  a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n) i_rd |-> !o_empty);

endmodule

// File: src/lcd_data_writer.sv
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_data_writer (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  logic                 i_enable,
  input  logic                 i_tearing_en,
  input  lcd_pkg::pix_fmt_e    i_format,
  input  logic [31:0]          i_num_pixels,
  input  lcd_pkg::pixel_word_u i_fifo_data,
  input  logic                 i_fifo_empty,
  input  logic                 i_tearing_effect,
  output logic                 o_fifo_rd,
  output logic                 o_frame_busy,
  output logic                 o_cmd_mode,
  output logic                 o_write,
  output logic [7:0]           o_data_out,
  output logic                 o_data_out_en
);

  localparam int CW = $clog2(`LCD_STROBE_CYCLES + 1);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_WAIT_TE = 3'd1;
  localparam logic [2:0] S_FETCH   = 3'd2;
  localparam logic [2:0] S_SETUP   = 3'd3;
  localparam logic [2:0] S_STROBE  = 3'd4;
  localparam logic [2:0] S_HOLD    = 3'd5;
  localparam logic [2:0] S_DONE    = 3'd6;

  logic [2:0]           r_state;
  logic [CW-1:0]        r_count;
  logic [1:0]           r_byte_idx;
  logic [31:0]          r_pix_count;
  logic [2:0]           r_te;
  lcd_pkg::pixel_word_u r_word;
  logic                 w_te_rise;
  logic                 w_is_888;
  logic                 w_pix_end;
  logic                 w_word_end;
  logic                 w_last_pix;
  logic [7:0]           w_byte;

  // Two-flop sync with a third stage for edge detect
  assign w_te_rise  = r_te[1] && !r_te[2];

  assign w_is_888   = (i_format == lcd_pkg::FMT_RGB888);
  assign w_pix_end  = w_is_888 ? (r_byte_idx == 2'd2) : r_byte_idx[0];
  assign w_word_end = w_is_888 ? (r_byte_idx == 2'd2) : (r_byte_idx == 2'd3);
  assign w_last_pix = (r_pix_count + 32'd1 == i_num_pixels);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state     <= S_IDLE;
      r_count     <= '0;
      r_byte_idx  <= '0;
      r_pix_count <= '0;
      r_te        <= '0;
    end else begin
      r_te <= {r_te[1:0], i_tearing_effect};
      if (!i_enable) begin
        r_state <= S_IDLE;
      end else begin
        case (r_state)
          S_IDLE: begin
            r_pix_count <= '0;
            if (i_num_pixels == '0) r_state <= S_DONE;
            else if (i_tearing_en)  r_state <= S_WAIT_TE;
            else                    r_state <= S_FETCH;
          end
          S_WAIT_TE: if (w_te_rise) r_state <= S_FETCH;
          S_FETCH: begin
            r_byte_idx <= '0;
            // Stall here without strobes while the FIFO is empty
            if (!i_fifo_empty) r_state <= S_SETUP;
          end
          S_SETUP: begin
            r_count <= '0;
            r_state <= S_STROBE;
          end
          S_STROBE: begin
            r_count <= r_count + 1'b1;
            if (r_count == CW'(`LCD_STROBE_CYCLES - 1)) r_state <= S_HOLD;
          end
          S_HOLD: begin
            if (w_pix_end) r_pix_count <= r_pix_count + 32'd1;
            if (w_pix_end && w_last_pix) begin
              r_state <= S_DONE;
            end else if (w_word_end) begin
              r_state <= S_FETCH;
            end else begin
              r_byte_idx <= r_byte_idx + 1'b1;
              r_state    <= S_SETUP;
            end
          end
          // Frame done and held until enable drops
          default: r_state <= r_state;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (o_fifo_rd) r_word <= i_fifo_data;
  end

  always_comb begin
    if (w_is_888) begin
      case (r_byte_idx)
        2'd0:    w_byte = r_word.rgb888.red;
        2'd1:    w_byte = r_word.rgb888.green;
        default: w_byte = r_word.rgb888.blue;
      endcase
    end else begin
      case (r_byte_idx)
        2'd0:    w_byte = r_word.rgb565.upper[15:8];
        2'd1:    w_byte = r_word.rgb565.upper[7:0];
        2'd2:    w_byte = r_word.rgb565.lower[15:8];
        default: w_byte = r_word.rgb565.lower[7:0];
      endcase
    end
  end

  assign o_fifo_rd     = (r_state == S_FETCH) && i_enable && !i_fifo_empty;
  assign o_frame_busy  = (r_state != S_IDLE) && (r_state != S_DONE);
  assign o_cmd_mode    = 1'b1;
  assign o_write       = (r_state == S_STROBE);
  assign o_data_out    = w_byte;
  assign o_data_out_en = (r_state == S_SETUP) || (r_state == S_STROBE) || (r_state == S_HOLD);

endmodule

// File: src/lcd_controller.sv
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_controller (
  input  logic                    clk,
  input  logic                    i_rst_n,

  input  logic                    i_reg_wr,
  input  lcd_pkg::reg_addr_e      i_reg_addr,
  input  logic [31:0]             i_reg_wdata,
  output logic [31:0]             o_reg_rdata,

  input  logic                    i_cmd_parameter,
  input  logic                    i_cmd_write_stb,
  input  logic                    i_cmd_read_stb,
  input  logic [7:0]              i_cmd_data,
  output logic [7:0]              o_cmd_data,
  output logic                    o_cmd_finished,

  input  logic                    i_fifo_stb,
  input  logic [31:0]             i_fifo_data,
  output logic [`LCD_LEVEL_W-1:0] o_fifo_level,

  output logic                    o_backlight_enable,
  output logic                    o_register_data_sel,
  output logic                    o_write_n,
  output logic                    o_read_n,
  inout  wire  [7:0]              io_data,
  output logic                    o_cs_n,
  output logic                    o_reset_n,
  input  logic                    i_tearing_effect,
  output logic                    o_display_on
);

  logic                    w_enable;
  logic                    w_reset_display;
  logic                    w_data_mode;
  logic                    w_tearing_en;
  logic                    w_backlight;
  logic                    w_chip_select;
  lcd_pkg::pix_fmt_e       w_format;
  logic [31:0]             w_num_pixels;
  logic [`LCD_LEVEL_W-1:0] w_fifo_level;
  logic                    w_frame_busy;

  logic                    w_cmd_mode;
  logic                    w_cmd_write;
  logic                    w_cmd_read;
  logic [7:0]              w_cmd_out;
  logic                    w_cmd_out_en;

  lcd_pkg::pixel_word_u    w_fifo_rdata;
  logic                    w_fifo_empty;
  logic                    w_fifo_rd;

  logic                    w_data_cmd_mode;
  logic                    w_data_write;
  logic [7:0]              w_data_out;
  logic                    w_data_out_en;
  logic                    w_bus_en;

  lcd_ctrl_regs u_regs (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_reg_wr        (i_reg_wr),
    .i_reg_addr      (i_reg_addr),
    .i_reg_wdata     (i_reg_wdata),
    .i_fifo_level    (w_fifo_level),
    .i_frame_busy    (w_frame_busy),
    .o_reg_rdata     (o_reg_rdata),
    .o_enable        (w_enable),
    .o_reset_display (w_reset_display),
    .o_data_mode     (w_data_mode),
    .o_tearing_en    (w_tearing_en),
    .o_backlight     (w_backlight),
    .o_chip_select   (w_chip_select),
    .o_format        (w_format),
    .o_num_pixels    (w_num_pixels)
  );

  lcd_command u_command (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_cmd_parameter (i_cmd_parameter),
    .i_cmd_write_stb (i_cmd_write_stb),
    .i_cmd_read_stb  (i_cmd_read_stb),
    .i_cmd_data      (i_cmd_data),
    .i_data_in       (io_data),
    .o_cmd_data      (o_cmd_data),
    .o_cmd_finished  (o_cmd_finished),
    .o_cmd_mode      (w_cmd_mode),
    .o_write         (w_cmd_write),
    .o_read          (w_cmd_read),
    .o_data_out      (w_cmd_out),
    .o_data_out_en   (w_cmd_out_en)
  );

  lcd_pixel_fifo u_fifo (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_wr    (i_fifo_stb),
    .i_wdata (i_fifo_data),
    .i_rd    (w_fifo_rd),
    .o_rdata (w_fifo_rdata),
    .o_empty (w_fifo_empty),
    .o_level (w_fifo_level)
  );

  // Frames only run while the data writer owns the bus
  lcd_data_writer u_writer (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_enable         (w_enable && w_data_mode),
    .i_tearing_en     (w_tearing_en),
    .i_format         (w_format),
    .i_num_pixels     (w_num_pixels),
    .i_fifo_data      (w_fifo_rdata),
    .i_fifo_empty     (w_fifo_empty),
    .i_tearing_effect (i_tearing_effect),
    .o_fifo_rd        (w_fifo_rd),
    .o_frame_busy     (w_frame_busy),
    .o_cmd_mode       (w_data_cmd_mode),
    .o_write          (w_data_write),
    .o_data_out       (w_data_out),
    .o_data_out_en    (w_data_out_en)
  );

  assign o_fifo_level       = w_fifo_level;
  assign o_backlight_enable = w_backlight;
  assign o_display_on       = w_enable;
  assign o_reset_n          = ~w_reset_display;
  assign o_cs_n             = ~w_chip_select;

  // Bus owner picked by data_mode; the data writer never reads
  assign o_register_data_sel = w_data_mode ? w_data_cmd_mode : w_cmd_mode;
  assign o_write_n           = w_data_mode ? ~w_data_write : ~w_cmd_write;
  assign o_read_n            = w_data_mode ? 1'b1 : ~w_cmd_read;
  assign w_bus_en            = w_data_mode ? w_data_out_en : w_cmd_out_en;
  assign io_data             = !w_bus_en ? 8'hzz : (w_data_mode ? w_data_out : w_cmd_out);

endmodule

// File: verification/tb_lcd_controller.sv
`timescale 1ns/1ps
`include "lcd_macros.svh"

module tb_lcd_controller;

  localparam int BYTE_CYCLES = 4;
  localparam int MAX_GAP     = 3;
  localparam int OP_OVERHEAD = 12;
  localparam int MARGIN      = 4;

  logic                    clk;
  logic                    rst_n;
  logic                    reg_wr;
  lcd_pkg::reg_addr_e      reg_addr;
  logic [31:0]             reg_wdata;
  logic [31:0]             reg_rdata;
  logic                    cmd_parameter;
  logic                    cmd_write_stb;
  logic                    cmd_read_stb;
  logic [7:0]              cmd_data_in;
  logic [7:0]              cmd_data_out;
  logic                    cmd_finished;
  logic                    fifo_stb;
  logic [31:0]             fifo_data;
  logic [`LCD_LEVEL_W-1:0] fifo_level;
  logic                    backlight_enable;
  logic                    register_data_sel;
  logic                    write_n;
  logic                    read_n;
  logic                    cs_n;
  logic                    reset_n;
  logic                    display_on;
  logic                    tearing_effect;
  wire  [7:0]              data_bus;
  logic [7:0]              panel_byte;

  bit          monitor_on;
  logic [8:0]  captured[$];
  logic [8:0]  expected[$];
  logic [3:0]  vec_op[$];
  logic [31:0] vec_a[$];
  logic [31:0] vec_b[$];
  int          cycle_count;
  int          cycle_limit;
  int          test_errors;
  int          total_errors;
  int          tests_passed;
  int          tests_failed;

  lcd_controller uut (
    .clk                 (clk),
    .i_rst_n             (rst_n),
    .i_reg_wr            (reg_wr),
    .i_reg_addr          (reg_addr),
    .i_reg_wdata         (reg_wdata),
    .o_reg_rdata         (reg_rdata),
    .i_cmd_parameter     (cmd_parameter),
    .i_cmd_write_stb     (cmd_write_stb),
    .i_cmd_read_stb      (cmd_read_stb),
    .i_cmd_data          (cmd_data_in),
    .o_cmd_data          (cmd_data_out),
    .o_cmd_finished      (cmd_finished),
    .i_fifo_stb          (fifo_stb),
    .i_fifo_data         (fifo_data),
    .o_fifo_level        (fifo_level),
    .o_backlight_enable  (backlight_enable),
    .o_register_data_sel (register_data_sel),
    .o_write_n           (write_n),
    .o_read_n            (read_n),
    .io_data             (data_bus),
    .o_cs_n              (cs_n),
    .o_reset_n           (reset_n),
    .i_tearing_effect    (tearing_effect),
    .o_display_on        (display_on)
  );

  always #10 clk = ~clk;

  // Panel side drives the bus only while the read strobe is low
  assign data_bus = read_n ? 8'hzz : panel_byte;

  // Panel latches on the rising edge of the write strobe
  always @(posedge write_n) begin
    if (monitor_on) captured.push_back({register_data_sel, data_bus});
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] exp_value,
                       input string what);
    if (actual !== exp_value) begin
      $display("Fail at %0t: %s (got %0h, expected %0h)", $time, what, actual, exp_value);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic load_vectors(output bit ok);
    int          fd;
    int          n;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    string       line;
    ok = 1'b0;
    fd = $fopen("verification/lcd_vectors.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Comment and blank lines do not scan as three fields
        n = $sscanf(line, "%h %h %h", op, a, b);
        if (n == 3) begin
          vec_op.push_back(op[3:0]);
          vec_a.push_back(a);
          vec_b.push_back(b);
        end
      end
      $fclose(fd);
      ok = (vec_op.size() > 0);
    end
  endtask

  task automatic reg_write(input lcd_pkg::reg_addr_e addr, input logic [31:0] data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
    // Panel control pins follow the control bits directly
    if (addr == lcd_pkg::REG_CONTROL) begin
      check(32'(display_on), 32'(data[0]), "display on output");
      check(32'(reset_n), 32'(!data[1]), "panel reset output");
      check(32'(backlight_enable), 32'(data[4]), "backlight output");
      check(32'(cs_n), 32'(!data[5]), "chip select output");
    end
  endtask

  task automatic reg_read(input lcd_pkg::reg_addr_e addr, input logic [31:0] exp_value);
    reg_addr = addr;
    @(negedge clk);
    check(reg_rdata, exp_value, $sformatf("register %0d read", addr));
    if (addr == lcd_pkg::REG_STATUS)
      check(32'(fifo_level), 32'(exp_value[15:0]), "FIFO level output");
  endtask

  // Cycles counted from the strobe up to the finished pulse
  task automatic wait_finished(input int exp_cycles, input string what);
    int cycles;
    cycles = 1;
    while (!cmd_finished) begin
      @(negedge clk);
      cycles++;
    end
    check(32'(cycles), 32'(exp_cycles), {what, " latency"});
    @(negedge clk);
    check(32'(cmd_finished), 32'd0, {what, " finished pulse width"});
  endtask

  task automatic cmd_write(input logic sel, input logic [7:0] value);
    cmd_parameter = sel;
    cmd_data_in   = value;
    cmd_write_stb = 1'b1;
    @(negedge clk);
    cmd_write_stb = 1'b0;
    // Setup, strobe low time and hold
    wait_finished(`LCD_STROBE_CYCLES + 2, "command write");
  endtask

  task automatic cmd_read(input logic [7:0] value);
    panel_byte   = value;
    cmd_read_stb = 1'b1;
    @(negedge clk);
    cmd_read_stb = 1'b0;
    wait_finished(`LCD_STROBE_CYCLES + 1, "command read");
    check(32'(cmd_data_out), 32'(value), "command read byte");
  endtask

  // Random idle gaps let the writer stall on an empty FIFO
  task automatic push_word(input logic [31:0] word);
    int gap;
    gap = int'($urandom_range(MAX_GAP, 0));
    repeat (gap) @(negedge clk);
    fifo_stb  = 1'b1;
    fifo_data = word;
    @(negedge clk);
    fifo_stb = 1'b0;
  endtask

  task automatic tearing_pulse();
    repeat (10) @(negedge clk);
    check(32'(captured.size()), 32'd0, "bytes sent before tearing edge");
    check(32'(write_n), 32'd1, "write strobe before tearing edge");
    tearing_effect = 1'b1;
    repeat (4) @(negedge clk);
    tearing_effect = 1'b0;
  endtask

  task automatic wait_frame_end();
    while (captured.size() < expected.size()) @(negedge clk);
    reg_addr = lcd_pkg::REG_STATUS;
    @(negedge clk);
    while (reg_rdata[16]) @(negedge clk);
  endtask

  task automatic finish_test(input int num);
    check(32'(captured.size()), 32'(expected.size()), "bus byte count");
    foreach (expected[i]) begin
      if (i < captured.size())
        check(32'(captured[i]), 32'(expected[i]), $sformatf("bus byte %0d {sel, data}", i));
    end
    if (test_errors == 0) begin
      $display("Test %0d finished: ok", num);
      tests_passed++;
    end else begin
      $display("Test %0d finished: %0d errors", num, test_errors);
      tests_failed++;
    end
    captured.delete();
    expected.delete();
    test_errors = 0;
  endtask

  task automatic run_record(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b);
    case (op)
      4'h1: reg_write(lcd_pkg::reg_addr_e'(a[1:0]), b);
      4'h2: reg_read(lcd_pkg::reg_addr_e'(a[1:0]), b);
      4'h3: cmd_write(a[0], b[7:0]);
      4'h4: cmd_read(b[7:0]);
      4'h5: push_word(b);
      4'h6: tearing_pulse();
      4'h7: expected.push_back({a[0], b[7:0]});
      4'h8: wait_frame_end();
      4'h9: finish_test(int'(a));
      default: begin
        $display("Unknown vector operation %0h", op);
        test_errors++;
        total_errors++;
      end
    endcase
  endtask

  initial begin
    bit loaded;
    clk            = 1'b0;
    rst_n          = 1'b0;
    reg_wr         = 1'b0;
    reg_addr       = lcd_pkg::REG_CONTROL;
    reg_wdata      = '0;
    cmd_parameter  = 1'b0;
    cmd_write_stb  = 1'b0;
    cmd_read_stb   = 1'b0;
    cmd_data_in    = '0;
    fifo_stb       = 1'b0;
    fifo_data      = '0;
    tearing_effect = 1'b0;
    panel_byte     = '0;
    void'($urandom(32'h8db07f07));
    load_vectors(loaded);
    if (!loaded) begin
      $display("Vector file verification/lcd_vectors.txt could not be read");
      $display("TEST FAILED");
    end else begin
      // Worst case per record is one word of four bytes plus a gap
      cycle_limit = 8 + vec_op.size() * (4 * BYTE_CYCLES + MAX_GAP + OP_OVERHEAD) * MARGIN;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      monitor_on = 1'b1;
      check(32'(write_n), 32'd1, "write strobe after reset");
      check(32'(read_n), 32'd1, "read strobe after reset");
      check(32'(cs_n), 32'd1, "chip select after reset");
      check(32'(reset_n), 32'd1, "panel reset after reset");
      check(32'(cmd_finished), 32'd0, "finished flag after reset");
      check(32'(data_bus === 8'hzz), 32'd1, "data bus released after reset");
      foreach (vec_op[i]) run_record(vec_op[i], vec_a[i], vec_b[i]);
      $display("Tests passed %0d, failed %0d, failed checks %0d",
               tests_passed, tests_failed, total_errors);
      if (total_errors == 0 && tests_failed == 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
    end
    $finish;
  end

endmodule

// File: lcd_controller.f
+incdir+src
src/lcd_pkg.sv
src/lcd_ctrl_regs.sv
src/lcd_command.sv
src/lcd_pixel_fifo.sv
src/lcd_data_writer.sv
src/lcd_controller.sv
verification/tb_lcd_controller.sv

// File: Makefile
# Verilator build and run of the LCD controller testbench

VERILATOR ?= verilator
TOP       ?= tb_lcd_controller
FILELIST  ?= lcd_controller.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/lcd_vectors.txt
# op a b in hex. 1 reg write addr data. 2 reg read addr expected. 3 command write sel byte
# 4 command read, b is the panel byte. 5 FIFO word. 6 tearing pulse. 7 expected sel byte
# 8 wait for frame end. 9 end of test, a is the test number
1 0 30
2 0 30
1 1 deadbeef
2 1 deadbeef
9 1 0
# Command byte then two parameter bytes
3 0 2a
3 1 00
3 1 10
7 0 2a
7 1 00
7 1 10
9 2 0
4 0 5c
4 0 a7
9 3 0
# RGB888 frame of 3 pixels, fourth word stays in the FIFO
1 1 3
1 0 25
5 0 00112233
5 0 00445566
5 0 00778899
5 0 12345678
7 1 11
7 1 22
7 1 33
7 1 44
7 1 55
7 1 66
7 1 77
7 1 88
7 1 99
8 0 0
2 2 1
9 4 0
# RGB565 frame of 5 pixels, starts with the word left over from test 4
1 0 24
1 1 5
1 0 65
5 0 abcdef01
5 0 5a5ac3c3
7 1 12
7 1 34
7 1 56
7 1 78
7 1 ab
7 1 cd
7 1 ef
7 1 01
7 1 5a
7 1 5a
8 0 0
2 2 0
9 5 0
# RGB888 frame held until the tearing edge
1 0 24
1 1 2
1 0 2d
5 0 00a1b2c3
5 0 00d4e5f6
6 0 0
7 1 a1
7 1 b2
7 1 c3
7 1 d4
7 1 e5
7 1 f6
8 0 0
2 2 0
9 6 0
